/* filelist.f */
common/video_pkg.sv
common/ctrl_pkg.sv
verilog/key_debounce.sv
verilog/video_ctrl.sv
capture/cam_pack.sv
capture/line_store.sv
display/disp_timing.sv
display/tone_map.sv
verilog/video_top.sv
bench/tb_video_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the video path testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing --timescale 1ns/1ps --top-module tb_video_top \
    -f filelist.f --Mdir obj_dir -o sim_tb_video_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb_video_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi

/* bench/tb_video_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_video_top
    import video_pkg::*;
    import ctrl_pkg::*;
();

    localparam int H_ACTIVE        = 16;
    localparam int H_TOTAL         = 24;
    localparam int V_ACTIVE        = 4;
    localparam int V_TOTAL         = 6;
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int RESET_CYCLES    = 5;
    localparam int NUM_TESTS       = 6;
    localparam int KEY_WAIT_LIMIT  = 4 * DEBOUNCE_CYCLES + 8;
    localparam int FRAME_CYCLES    = V_TOTAL * H_TOTAL;
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * 3 * FRAME_CYCLES + 4 * FRAME_CYCLES;
    localparam logic [31:0] RAND_SEED = 32'hbd91a468;

    typedef struct packed {
        logic [15:0] seed;                          // xor'd into the random pixels
        logic        mirror_key;
        logic        mono_key;
    } test_entry_t;

    logic       core_clk;
    logic       reset_i;
    logic [7:0] cam_data_i;
    logic       cam_valid_i;
    logic       cam_href_i;
    logic       cam_vsync_i;
    logic       key_mirror_i;
    logic       key_mono_i;
    logic       hs_o;
    logic       vs_o;
    logic       de_o;
    rgb888_t    rgb_o;
    disp_mode_t mode_o;

    test_entry_t tests [NUM_TESTS];
    logic [15:0] new_line [H_ACTIVE];               // line being sent
    logic [15:0] old_line [H_ACTIVE];               // line shown before it
    logic        old_valid;                         // zero when nothing captured yet
    disp_mode_t  exp_mode;
    logic        tear_en;                           // monitor checks old/new match
    rgb888_t     line_buf [H_ACTIVE];
    rgb888_t     disp_line [H_ACTIVE];              // last complete display line
    int          pix_cnt;
    logic        de_seen;
    int          lines_done;
    int          err_cnt;
    int          check_cnt;
    int          mon_err_cnt;                       // monitor keeps its own counts
    int          mon_check_cnt;
    int          cycle_cnt;
    int          disp_pos;                          // cycles since reset released
    logic [2:0]  exp_sync;                          // hs, vs, de
    int          t;
    int          i;

    video_top #(
        .H_ACTIVE        (H_ACTIVE),
        .H_TOTAL         (H_TOTAL),
        .V_ACTIVE        (V_ACTIVE),
        .V_TOTAL         (V_TOTAL),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_video_top (
        .core_clk     (core_clk),
        .reset_i      (reset_i),
        .cam_data_i   (cam_data_i),
        .cam_valid_i  (cam_valid_i),
        .cam_href_i   (cam_href_i),
        .cam_vsync_i  (cam_vsync_i),
        .key_mirror_i (key_mirror_i),
        .key_mono_i   (key_mono_i),
        .hs_o         (hs_o),
        .vs_o         (vs_o),
        .de_o         (de_o),
        .rgb_o        (rgb_o),
        .mode_o       (mode_o)
    );

    always #20 core_clk = ~core_clk;               // 40 ns period

    //////////////////////////////////////////////////////////////////////
    // expected values and compare tasks
    //////////////////////////////////////////////////////////////////////

    // 565 to 888 by zero padding, mono copies green everywhere
    function automatic rgb888_t expand_pix(input logic [15:0] raw, input logic mono);
        rgb888_t px;
        px.r = {raw[15:11], 3'b000};
        px.g = {raw[10:5], 2'b00};
        px.b = {raw[4:0], 3'b000};
        if (mono)
        begin
            px.r = px.g;
            px.b = px.g;
        end
        return px;
    endfunction

    function automatic rgb888_t expected_at(input int col, input logic use_new);
        int      src;
        rgb888_t px;
        src = exp_mode.mirror ? (H_ACTIVE - 1 - col) : col;    // mirrored column order
        px  = '0;                                               // black before first line
        if (use_new)
            px = expand_pix(new_line[src], exp_mode.mono);
        else if (old_valid)
            px = expand_pix(old_line[src], exp_mode.mono);
        return px;
    endfunction

    // hs, vs, de for the n-th cycle after reset drops
    function automatic logic [2:0] expected_sync(input int n);
        int         p;
        int         h;
        int         v;
        logic [2:0] s;
        s = 3'b000;                                 // all low right after reset
        if (n >= 2)
        begin
            p    = n - 2;                           // two cycle output delay
            h    = p % H_TOTAL;
            v    = (p / H_TOTAL) % V_TOTAL;
            s[2] = (h >= H_TOTAL - 4);              // hs on last 4 cycles
            s[1] = (v == V_TOTAL - 1);              // vs on last line
            s[0] = (h < H_ACTIVE) && (v < V_ACTIVE);
        end
        return s;
    endfunction

    task automatic check_pix(input rgb888_t got, input rgb888_t exp, input string what);
        check_cnt = check_cnt + 1;
        if (got !== exp)
        begin
            $display("CHECK FAILED @ %0t: %s got %06h expected %06h", $time, what, got, exp);
            err_cnt = err_cnt + 1;
        end
    endtask

    task automatic check_mode(input disp_mode_t got, input disp_mode_t exp, input string what);
        check_cnt = check_cnt + 1;
        if (got !== exp)
        begin
            $display("CHECK FAILED @ %0t: %s got %02b expected %02b", $time, what, got, exp);
            err_cnt = err_cnt + 1;
        end
    endtask

    task automatic check_sync(input logic got, input logic exp, input string what);
        mon_check_cnt = mon_check_cnt + 1;
        if (got !== exp)
        begin
            $display("CHECK FAILED @ %0t: %s got %0b expected %0b", $time, what, got, exp);
            mon_err_cnt = mon_err_cnt + 1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // display monitor
    //////////////////////////////////////////////////////////////////////

    task automatic finish_line();
        logic ok_old;
        logic ok_new;
        int   k;
        ok_old        = 1'b1;
        ok_new        = 1'b1;
        mon_check_cnt = mon_check_cnt + 1;
        if (pix_cnt != H_ACTIVE)
        begin
            $display("CHECK FAILED @ %0t: display line carried %0d pixels, expected %0d",
                     $time, pix_cnt, H_ACTIVE);
            mon_err_cnt = mon_err_cnt + 1;
        end
        for (k = 0; k < H_ACTIVE; k++)
        begin
            disp_line[k] = line_buf[k];
            if (line_buf[k] !== expected_at(k, 1'b0))
                ok_old = 1'b0;
            if (line_buf[k] !== expected_at(k, 1'b1))
                ok_new = 1'b0;
        end
        if (tear_en && !ok_old && !ok_new)
        begin
            $display("CHECK FAILED @ %0t: display line matches neither old nor new line",
                     $time);                        // torn line
            mon_err_cnt = mon_err_cnt + 1;
        end
        lines_done = lines_done + 1;
    endtask

    // outputs sampled mid-cycle, away from the rising edge
    always @(negedge core_clk)
    begin
        if (reset_i)
        begin
            pix_cnt = 0;
            de_seen = 1'b0;
        end
        else if (de_o)
        begin
            if (pix_cnt < H_ACTIVE)
                line_buf[pix_cnt] = rgb_o;
            pix_cnt = pix_cnt + 1;
            de_seen = 1'b1;
        end
        else if (de_seen)
        begin
            finish_line();                          // de just fell
            pix_cnt = 0;
            de_seen = 1'b0;
        end
    end

    // sync outputs against a free running line and frame position
    always @(negedge core_clk)
    begin
        if (reset_i === 1'b0)
        begin
            exp_sync = expected_sync(disp_pos);
            check_sync(hs_o, exp_sync[2], "hs_o");
            check_sync(vs_o, exp_sync[1], "vs_o");
            check_sync(de_o, exp_sync[0], "de_o");
        end
    end

    always @(posedge core_clk)
    begin
        if (reset_i === 1'b0)
            disp_pos = disp_pos + 1;
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
            $display("summary: %0d checks, %0d errors", check_cnt + mon_check_cnt,
                     err_cnt + mon_err_cnt);
            $display("Checks failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic load_tests();
        tests[0] = '{seed: 16'h1234, mirror_key: 1'b0, mono_key: 1'b0};   // first line
        tests[1] = '{seed: 16'h5a5a, mirror_key: 1'b0, mono_key: 1'b0};   // plain swap
        tests[2] = '{seed: 16'hc3e1, mirror_key: 1'b1, mono_key: 1'b0};   // mirror on
        tests[3] = '{seed: 16'h0f0f, mirror_key: 1'b0, mono_key: 1'b1};   // mono on
        tests[4] = '{seed: 16'h7e81, mirror_key: 1'b1, mono_key: 1'b0};   // mirror off
        tests[5] = '{seed: 16'h9bd2, mirror_key: 1'b0, mono_key: 1'b1};   // mono off
    endtask

    task automatic make_line(input logic [15:0] seed);
        int k;
        for (k = 0; k < H_ACTIVE; k++)
            new_line[k] = 16'($urandom()) ^ seed;
    endtask

    task automatic wait_hs_fall();
        logic hs_prev;
        hs_prev = 1'b0;
        @(negedge core_clk);
        while (!(hs_prev && !hs_o))
        begin
            hs_prev = hs_o;
            @(negedge core_clk);
        end
    endtask

    task automatic wait_de_rise();
        @(negedge core_clk);
        while (de_o)
            @(negedge core_clk);                    // let the current line finish
        while (!de_o)
            @(negedge core_clk);
    endtask

    task automatic wait_line_done();
        int start;
        @(posedge core_clk);
        start = lines_done;
        while (lines_done == start)
            @(posedge core_clk);
    endtask

    task automatic press_key(input logic use_mono, input disp_mode_t want);
        int waited;
        waited = 0;
        @(posedge core_clk);
        #1;
        if (use_mono)
            key_mono_i = 1'b1;
        else
            key_mirror_i = 1'b1;
        while ((mode_o !== want) && (waited < KEY_WAIT_LIMIT))
        begin
            @(negedge core_clk);
            waited = waited + 1;
        end
        if (waited >= KEY_WAIT_LIMIT)
        begin
            $display("key press gave no mode change within %0d cycles", KEY_WAIT_LIMIT);
            err_cnt = err_cnt + 1;
        end
        else if (waited < DEBOUNCE_CYCLES)
        begin
            $display("mode changed after %0d cycles, before the key was debounced", waited);
            err_cnt = err_cnt + 1;
        end
        check_mode(mode_o, want, "mode after press");
        @(posedge core_clk);
        #1;
        key_mirror_i = 1'b0;
        key_mono_i   = 1'b0;
        repeat (DEBOUNCE_CYCLES + 6) @(posedge core_clk);   // release settles too
        @(negedge core_clk);
        check_mode(mode_o, want, "mode after release");     // release must not toggle
    endtask

    // two bytes per pixel, high byte first, then href drops
    task automatic send_line();
        int k;
        for (k = 0; k < H_ACTIVE; k++)
        begin
            @(posedge core_clk);
            #1;
            cam_href_i  = 1'b1;
            cam_valid_i = 1'b1;
            cam_data_i  = new_line[k][15:8];
            @(posedge core_clk);
            #1;
            cam_data_i  = new_line[k][7:0];
        end
        @(posedge core_clk);
        #1;
        cam_href_i  = 1'b0;                         // line_end follows
        cam_valid_i = 1'b0;
        cam_data_i  = 8'h00;
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        core_clk      = 1'b0;
        reset_i       = 1'b1;
        cam_data_i    = 8'h00;
        cam_valid_i   = 1'b0;
        cam_href_i    = 1'b0;
        cam_vsync_i   = 1'b0;
        key_mirror_i  = 1'b0;
        key_mono_i    = 1'b0;
        old_valid     = 1'b0;
        tear_en       = 1'b0;
        exp_mode      = '0;
        lines_done    = 0;
        err_cnt       = 0;
        check_cnt     = 0;
        mon_err_cnt   = 0;
        mon_check_cnt = 0;
        cycle_cnt     = 0;
        disp_pos      = 0;
        void'($urandom(RAND_SEED));                 // one seed for the whole run
        load_tests();
        repeat (RESET_CYCLES) @(posedge core_clk);
        #1;
        reset_i = 1'b0;

        @(negedge core_clk);
        check_mode(mode_o, exp_mode, "mode after reset");

        // nothing captured yet, display must be black
        wait_line_done();
        for (i = 0; i < H_ACTIVE; i++)
            check_pix(disp_line[i], '0, "empty store pixel");

        for (t = 0; t < NUM_TESTS; t++)
        begin
            tear_en = 1'b0;                         // mode may change mid line
            if (tests[t].mirror_key)
            begin
                exp_mode.mirror = ~exp_mode.mirror;
                press_key(1'b0, exp_mode);
            end
            if (tests[t].mono_key)
            begin
                exp_mode.mono = ~exp_mode.mono;
                press_key(1'b1, exp_mode);
            end
            make_line(tests[t].seed);
            wait_hs_fall();
            wait_hs_fall();                         // mirror latched on a line edge
            tear_en = 1'b1;
            send_line();
            wait_de_rise();                         // first line started after line_end
            wait_line_done();
            for (i = 0; i < H_ACTIVE; i++)
                check_pix(disp_line[i], expected_at(i, 1'b1), "shown pixel");
            old_line  = new_line;
            old_valid = 1'b1;
        end

        $display("summary: %0d checks, %0d errors", check_cnt + mon_check_cnt,
                 err_cnt + mon_err_cnt);
        if ((err_cnt + mon_err_cnt) == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/video_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_top
    import video_pkg::*;
    import ctrl_pkg::*;
#(
    parameter int H_ACTIVE        = 640,        // pixels per line, store depth
    parameter int H_TOTAL         = 800,        // display line period
    parameter int V_ACTIVE        = 480,
    parameter int V_TOTAL         = 525,
    parameter int DEBOUNCE_CYCLES = 500000      // key settle time in core_clk cycles
)
(
    input  wire logic       core_clk,
    input  wire logic       reset_i,
    input  wire logic [7:0] cam_data_i,         // camera byte
    input  wire logic       cam_valid_i,        // byte strobe
    input  wire logic       cam_href_i,
    input  wire logic       cam_vsync_i,
    input  wire logic       key_mirror_i,
    input  wire logic       key_mono_i,
    output logic            hs_o,
    output logic            vs_o,
    output logic            de_o,
    output rgb888_t         rgb_o,
    output disp_mode_t      mode_o
);

    rgb565_t   cap_pix;                         // packed camera pixel
    logic      cap_valid;
    pix_addr_t cap_col;
    logic      line_end;
    logic      line_start;
    logic      wr_bank;
    logic      rd_bank;
    logic      line_ready;
    logic      mirror_press;
    logic      mono_press;
    logic      rd_en;
    pix_addr_t rd_addr;
    rgb565_t   rd_pix;                          // store output, one cycle after rd_addr

    //////////////////////////////////////////////////////////////////////
    // capture side
    //////////////////////////////////////////////////////////////////////

    cam_pack #(
        .H_ACTIVE    (H_ACTIVE)
    ) u_cam_pack (
        .core_clk    (core_clk),
        .reset_i     (reset_i),
        .cam_data_i  (cam_data_i),
        .cam_valid_i (cam_valid_i),
        .cam_href_i  (cam_href_i),
        .cam_vsync_i (cam_vsync_i),
        .pix_o       (cap_pix),
        .pix_valid_o (cap_valid),
        .pix_col_o   (cap_col),
        .line_end_o  (line_end)
    );

    line_store #(
        .H_ACTIVE  (H_ACTIVE)
    ) u_line_store (
        .core_clk  (core_clk),
        .wr_en_i   (cap_valid),
        .wr_bank_i (wr_bank),
        .wr_addr_i (cap_col),
        .wr_pix_i  (cap_pix),
        .rd_en_i   (rd_en),
        .rd_bank_i (rd_bank),
        .rd_addr_i (rd_addr),
        .rd_pix_o  (rd_pix)
    );

    //////////////////////////////////////////////////////////////////////
    // control and keys
    //////////////////////////////////////////////////////////////////////

    key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_key_mirror (
        .core_clk (core_clk),
        .reset_i  (reset_i),
        .key_i    (key_mirror_i),
        .press_o  (mirror_press)
    );

    key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_key_mono (
        .core_clk (core_clk),
        .reset_i  (reset_i),
        .key_i    (key_mono_i),
        .press_o  (mono_press)
    );

    video_ctrl u_video_ctrl (
        .core_clk       (core_clk),
        .reset_i        (reset_i),
        .line_end_i     (line_end),
        .line_start_i   (line_start),
        .mirror_press_i (mirror_press),
        .mono_press_i   (mono_press),
        .wr_bank_o      (wr_bank),
        .rd_bank_o      (rd_bank),
        .line_ready_o   (line_ready),
        .mode_o         (mode_o)
    );

    //////////////////////////////////////////////////////////////////////
    // display side
    //////////////////////////////////////////////////////////////////////

    disp_timing #(
        .H_ACTIVE     (H_ACTIVE),
        .H_TOTAL      (H_TOTAL),
        .V_ACTIVE     (V_ACTIVE),
        .V_TOTAL      (V_TOTAL)
    ) u_disp_timing (
        .core_clk     (core_clk),
        .reset_i      (reset_i),
        .mirror_i     (mode_o.mirror),
        .line_start_o (line_start),
        .rd_en_o      (rd_en),
        .rd_addr_o    (rd_addr),
        .hs_o         (hs_o),           // already delayed to match rgb_o
        .vs_o         (vs_o),
        .de_o         (de_o)
    );

    tone_map u_tone_map (
        .core_clk     (core_clk),
        .reset_i      (reset_i),
        .pix_i        (rd_pix),
        .mono_i       (mode_o.mono),
        .valid_i      (rd_en),
        .line_ready_i (line_ready),
        .rgb_o        (rgb_o)
    );

endmodule

`default_nettype wire

/* display/tone_map.sv */
`timescale 1ns/1ps
`default_nettype none

module tone_map
    import video_pkg::*;
(
    input  wire logic    core_clk,
    input  wire logic    reset_i,
    input  wire rgb565_t pix_i,                 // from the store read port
    input  wire logic    mono_i,
    input  wire logic    valid_i,               // store read enable
    input  wire logic    line_ready_i,
    output rgb888_t      rgb_o
);

    logic    valid_q;                           // lines up with pix_i
    rgb888_t expanded;

    // zero-pad each channel to 8 bits
    always_comb
    begin
        expanded.r = {pix_i.r, 3'b000};
        expanded.g = {pix_i.g, 2'b00};
        expanded.b = {pix_i.b, 3'b000};
        if (mono_i)
        begin
            expanded.r = expanded.g;            // green carries the most detail
            expanded.b = expanded.g;
        end
    end

    always_ff @(posedge core_clk)
    begin
        if (reset_i)
            valid_q <= 1'b0;
        else
            valid_q <= valid_i;
    end

    always_ff @(posedge core_clk)
    begin
        rgb_o <= (valid_q && line_ready_i) ? expanded : '0;  // black until a line is in
    end

endmodule

`default_nettype wire

/* display/disp_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module disp_timing
    import video_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_TOTAL  = 525
)
(
    input  wire logic core_clk,
    input  wire logic reset_i,
    input  wire logic mirror_i,
    output logic      line_start_o,             // cycle before column 0
    output logic      rd_en_o,
    output pix_addr_t rd_addr_o,
    output logic      hs_o,                     // two cycles behind the counters
    output logic      vs_o,
    output logic      de_o
);

    localparam int               H_W      = $clog2(H_TOTAL);
    localparam int               V_W      = $clog2(V_TOTAL);
    localparam logic [H_W-1:0]   H_LAST   = H_W'(H_TOTAL - 1);
    localparam logic [H_W-1:0]   H_ACT    = H_W'(H_ACTIVE);
    localparam logic [H_W-1:0]   HS_BEGIN = H_W'(H_TOTAL - 4);  // last 4 cycles
    localparam logic [V_W-1:0]   V_LAST   = V_W'(V_TOTAL - 1);
    localparam logic [V_W-1:0]   V_ACT    = V_W'(V_ACTIVE);
    localparam pix_addr_t        COL_LAST = pix_addr_t'(H_ACTIVE - 1);

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic           mirror_q;                   // held for a whole line
    logic           de_raw;
    pix_addr_t      col;
    logic           hs_d;
    logic           vs_d;
    logic           de_d;

    assign de_raw       = (h_cnt < H_ACT) && (v_cnt < V_ACT);
    assign line_start_o = (h_cnt == H_LAST);
    assign col          = pix_addr_t'(h_cnt);
    assign rd_en_o      = de_raw;
    assign rd_addr_o    = mirror_q ? (COL_LAST - col) : col;

    always_ff @(posedge core_clk)
    begin
        if (reset_i)
        begin
            h_cnt    <= '0;
            v_cnt    <= '0;
            mirror_q <= 1'b0;
            hs_d     <= 1'b0;
            vs_d     <= 1'b0;
            de_d     <= 1'b0;
            hs_o     <= 1'b0;
            vs_o     <= 1'b0;
            de_o     <= 1'b0;
        end
        else
        begin
            if (h_cnt == H_LAST)
            begin
                h_cnt    <= '0;
                v_cnt    <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
                mirror_q <= mirror_i;               // flip only between lines
            end
            else
                h_cnt <= h_cnt + 1'b1;

            // stage 1 matches the store read, stage 2 the tone map
            hs_d <= (h_cnt >= HS_BEGIN);
            vs_d <= (v_cnt == V_LAST);
            de_d <= de_raw;
            hs_o <= hs_d;
            vs_o <= vs_d;
            de_o <= de_d;
        end
    end

endmodule

`default_nettype wire

/* capture/line_store.sv */
`timescale 1ns/1ps
`default_nettype none

module line_store
    import video_pkg::*;
#(
    parameter int H_ACTIVE = 640                // depth of each bank
)
(
    input  wire logic      core_clk,
    input  wire logic      wr_en_i,
    input  wire logic      wr_bank_i,
    input  wire pix_addr_t wr_addr_i,
    input  wire rgb565_t   wr_pix_i,
    input  wire logic      rd_en_i,
    input  wire logic      rd_bank_i,
    input  wire pix_addr_t rd_addr_i,           // already mirrored if needed
    output rgb565_t        rd_pix_o             // valid one cycle after rd_en_i
);

    localparam int AW = $clog2(H_ACTIVE);

    rgb565_t bank_mem [0:1][0:H_ACTIVE-1];      // ping-pong line banks

    logic [AW-1:0] wr_col;
    logic [AW-1:0] rd_col;

    assign wr_col = wr_addr_i[AW-1:0];          // callers keep columns in range
    assign rd_col = rd_addr_i[AW-1:0];

    // camera write port
    always_ff @(posedge core_clk)
    begin
        if (wr_en_i)
            bank_mem[wr_bank_i][wr_col] <= wr_pix_i;
    end

    // display read port, registered
    always_ff @(posedge core_clk)
    begin
        if (rd_en_i)
            rd_pix_o <= bank_mem[rd_bank_i][rd_col];
    end

endmodule

`default_nettype wire

/* capture/cam_pack.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_pack
    import video_pkg::*;
#(
    parameter int H_ACTIVE = 640                // columns kept per line
)
(
    input  wire logic       core_clk,
    input  wire logic       reset_i,
    input  wire logic [7:0] cam_data_i,
    input  wire logic       cam_valid_i,        // byte strobe
    input  wire logic       cam_href_i,         // line active
    input  wire logic       cam_vsync_i,        // frame restart
    output rgb565_t         pix_o,
    output logic            pix_valid_o,
    output pix_addr_t       pix_col_o,
    output logic            line_end_o          // href fell after pixels
);

    localparam pix_addr_t COL_LIMIT = pix_addr_t'(H_ACTIVE);

    logic       byte_phase;                     // 0 expects high byte
    logic [7:0] hi_byte;
    pix_addr_t  col_cnt;                        // next column to write
    logic       href_d;

    always_ff @(posedge core_clk)
    begin
        if (reset_i)
        begin
            byte_phase  <= 1'b0;
            col_cnt     <= '0;
            href_d      <= 1'b0;
            pix_valid_o <= 1'b0;
            line_end_o  <= 1'b0;
        end
        else
        begin
            href_d      <= cam_href_i;
            pix_valid_o <= 1'b0;
            line_end_o  <= 1'b0;
            if (cam_vsync_i || !cam_href_i)
            begin
                byte_phase <= 1'b0;
                col_cnt    <= '0;
                line_end_o <= href_d && !cam_href_i && !cam_vsync_i && (col_cnt != '0);
            end
            else if (cam_valid_i)
            begin
                byte_phase <= ~byte_phase;
                if (byte_phase && (col_cnt < COL_LIMIT))
                begin
                    pix_valid_o <= 1'b1;            // overlong lines are dropped
                    col_cnt     <= col_cnt + 1'b1;
                end
            end
        end
    end

    // pixel data path
    always_ff @(posedge core_clk)
    begin
        if (cam_valid_i && cam_href_i)
        begin
            if (!byte_phase)
                hi_byte <= cam_data_i;
            else
            begin
                pix_o     <= {hi_byte, cam_data_i}; // high byte first
                pix_col_o <= col_cnt;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/video_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module video_ctrl
    import ctrl_pkg::*;
(
    input  wire logic core_clk,
    input  wire logic reset_i,
    input  wire logic line_end_i,               // captured line complete
    input  wire logic line_start_i,             // display about to start a line
    input  wire logic mirror_press_i,
    input  wire logic mono_press_i,
    output logic      wr_bank_o,                // bank the camera writes
    output logic      rd_bank_o,                // bank the display reads
    output logic      line_ready_o,             // read bank holds a full line
    output disp_mode_t mode_o
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;

    // fill tracking
    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_EMPTY:
                if (line_end_i)
                    state_nxt = ST_READY;           // line done before display started
                else if (line_start_i)
                    state_nxt = ST_FILL;            // display running, still waiting
            ST_FILL:
                if (line_end_i)
                    state_nxt = ST_READY;
            ST_READY:
                state_nxt = ST_READY;               // stays until reset
            default:
                state_nxt = ST_EMPTY;
        endcase
    end

    always_ff @(posedge core_clk)
    begin
        if (reset_i)
        begin
            state        <= ST_EMPTY;
            wr_bank_o    <= 1'b0;
            rd_bank_o    <= 1'b1;
            line_ready_o <= 1'b0;
            mode_o       <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (line_end_i)
                wr_bank_o <= ~wr_bank_o;            // finished bank becomes readable

            // read side only moves between display lines, so no tearing
            if (line_start_i)
            begin
                rd_bank_o    <= ~wr_bank_o;
                line_ready_o <= (state == ST_READY);
            end

            if (mirror_press_i)
                mode_o.mirror <= ~mode_o.mirror;
            if (mono_press_i)
                mode_o.mono <= ~mode_o.mono;
        end
    end

endmodule

`default_nettype wire

/* verilog/key_debounce.sv */
`timescale 1ns/1ps
`default_nettype none

module key_debounce
#(
    parameter int DEBOUNCE_CYCLES = 500000      // cycles the key must stay put
)
(
    input  wire logic core_clk,
    input  wire logic reset_i,
    input  wire logic key_i,                    // raw key, async
    output logic      press_o                   // one pulse per debounced press
);

    localparam int               CNT_W    = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic             key_s1;                   // sync stage 1
    logic             key_s2;                   // sync stage 2
    logic             key_db;                   // accepted key level
    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge core_clk)
    begin
        if (reset_i)
        begin
            key_s1     <= 1'b0;
            key_s2     <= 1'b0;
            key_db     <= 1'b0;
            stable_cnt <= '0;
            press_o    <= 1'b0;
        end
        else
        begin
            key_s1  <= key_i;
            key_s2  <= key_s1;
            press_o <= 1'b0;
            if (key_s2 == key_db)
                stable_cnt <= '0;                   // bounce, start over
            else if (stable_cnt == CNT_LAST)
            begin
                stable_cnt <= '0;
                key_db     <= key_s2;
                press_o    <= key_s2;               // rising edge only
            end
            else
                stable_cnt <= stable_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* common/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    // line store fill state
    typedef enum logic [1:0] {
        ST_EMPTY = 2'd0,                        // nothing captured, display idle
        ST_FILL  = 2'd1,                        // display running, no full line yet
        ST_READY = 2'd2                         // read bank holds a complete line
    } ctrl_state_e;

    // user display options, toggled by the keys
    typedef struct packed {
        logic mirror;                           // horizontal flip
        logic mono;                             // green channel on all three
    } disp_mode_t;

endpackage

`default_nettype wire

/* common/video_pkg.sv */
`default_nettype none

package video_pkg;

    //////////////////////////////////////////////////////////////////////
    // pixel formats
    //////////////////////////////////////////////////////////////////////

    // camera side pixel, two bytes high first
    typedef struct packed {
        logic [4:0] r;                          // red in top bits
        logic [5:0] g;                          // green gets the extra bit
        logic [4:0] b;
    } rgb565_t;

    // display side pixel
    typedef struct packed {
        logic [7:0] r;                          // red in top byte
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    //////////////////////////////////////////////////////////////////////
    // line store addressing
    //////////////////////////////////////////////////////////////////////

    localparam int PIX_ADDR_W = 10;             // up to 1024 columns

    typedef logic [PIX_ADDR_W-1:0] pix_addr_t;  // column index

endpackage

`default_nettype wire
